//--- rtl/copy_pkg.sv
`default_nettype none

package copy_pkg;

   localparam int ADDR_W     = 12;
   localparam int PERIOD_W   = 10;
   localparam int DELAY_W    = 7;
   localparam int DATA_W     = 32;
   localparam int OFFSET_W   = $clog2(DATA_W / 8);
   localparam int MEM_WORDS  = 1024;
   localparam int WORD_AW    = $clog2(MEM_WORDS);
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   typedef struct packed {
      logic        [ADDR_W-1:0]   start;
      logic        [PERIOD_W-1:0] duty;
      logic        [PERIOD_W-1:0] period;
      logic signed [ADDR_W-1:0]   incr;        // in words
      logic        [ADDR_W-1:0]   iterations;
      logic signed [ADDR_W-1:0]   shift;       // in words, applied at the end of a period
      logic        [DELAY_W-1:0]  delay;
   } agu_cfg_t;

   typedef struct packed {
      logic              we;
      logic [WORD_AW-1:0] addr;
      logic [DATA_W-1:0]  wdata;
   } mem_req_t;

   typedef enum logic [1:0] {HOP_IDLE, HOP_READ, HOP_WRITE} host_op_e;

   typedef enum logic [1:0] {GNT_NONE, GNT_HOST, GNT_WR, GNT_RD} grant_e;

   typedef enum logic [1:0] {AG_IDLE, AG_DELAY, AG_RUN} agu_state_e;

endpackage

`default_nettype wire

//--- rtl/addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

module addr_gen import copy_pkg::*; (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   input  wire logic              run_i,
   input  wire agu_cfg_t          cfg_i,
   output logic                   valid_o,
   input  wire logic              ready_i,
   output logic [ADDR_W-1:0]      addr_o,
   output logic                   done_o
);

   agu_state_e state_q;

   logic [DELAY_W-1:0]  delay_cnt_q;
   logic [PERIOD_W-1:0] per_q;
   logic [ADDR_W-1:0]   iter_q;

   logic                per_last;
   logic                iter_last;
   logic [ADDR_W-1:0]   incr_step;
   logic [ADDR_W-1:0]   shift_step;

   // a zero count behaves as a count of one
   assign per_last  = ((per_q + 1'b1) == cfg_i.period) || (cfg_i.period == '0);
   assign iter_last = ((iter_q + 1'b1) == cfg_i.iterations) || (cfg_i.iterations == '0);

   assign incr_step  = {cfg_i.incr[ADDR_W-1-OFFSET_W:0], {OFFSET_W{1'b0}}};   // words to bytes
   assign shift_step = {cfg_i.shift[ADDR_W-1-OFFSET_W:0], {OFFSET_W{1'b0}}};

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q     <= AG_IDLE;
         delay_cnt_q <= '0;
         per_q       <= '0;
         iter_q      <= '0;
         addr_o      <= '0;
         valid_o     <= 1'b0;
         done_o      <= 1'b1;
      end else if (run_i) begin
         delay_cnt_q <= cfg_i.delay;
         per_q       <= '0;
         iter_q      <= '0;
         addr_o      <= cfg_i.start;
         done_o      <= 1'b0;
         if (cfg_i.delay == '0) begin
            state_q <= AG_RUN;
            valid_o <= 1'b1;
         end else begin
            state_q <= AG_DELAY;
            valid_o <= 1'b0;
         end
      end else begin
         unique case (state_q)
            AG_DELAY: begin
               delay_cnt_q <= delay_cnt_q - 1'b1;
               if (delay_cnt_q == 1) begin
                  state_q <= AG_RUN;
                  valid_o <= 1'b1;
               end
            end
            AG_RUN: begin
               if (valid_o && ready_i) begin
                  if (per_last && iter_last) begin
                     state_q <= AG_IDLE;
                     valid_o <= 1'b0;
                     done_o  <= 1'b1;
                     per_q   <= '0;
                     iter_q  <= '0;
                  end else if (per_last) begin
                     addr_o <= addr_o + shift_step;
                     per_q  <= '0;
                     iter_q <= iter_q + 1'b1;
                  end else begin
                     if (per_q < cfg_i.duty) begin
                        addr_o <= addr_o + incr_step;   // only the duty part of a period moves
                     end
                     per_q <= per_q + 1'b1;
                  end
               end
            end
            default: begin
               valid_o <= 1'b0;
            end
         endcase
      end
   end

   a_valid_not_done: assert property (@(posedge clk_i) disable iff (rst_i)
      !(valid_o && done_o));

   // an offered address must not move until it is taken
   a_addr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (valid_o && !ready_i && !run_i) |=> (valid_o && $stable(addr_o)));

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter import copy_pkg::*; (
   input  wire logic               clk_i,
   input  wire logic               rst_i,

   input  wire host_op_e           host_op_i,
   input  wire logic [WORD_AW-1:0] host_addr_i,
   input  wire logic [DATA_W-1:0]  host_wdata_i,
   output logic                    host_gnt_o,

   input  wire logic               rd_req_i,
   input  wire logic [WORD_AW-1:0] rd_addr_i,
   output logic                    rd_gnt_o,

   input  wire logic               wr_req_i,
   input  wire logic [WORD_AW-1:0] wr_addr_i,
   input  wire logic [DATA_W-1:0]  wr_wdata_i,
   output logic                    wr_gnt_o,

   output mem_req_t                mem_req_o,
   output logic                    mem_en_o,
   input  wire logic [DATA_W-1:0]  mem_rdata_i,

   output logic                    host_rvalid_o,
   output logic [DATA_W-1:0]       host_rdata_o,
   output logic                    rd_rvalid_o,
   output logic [DATA_W-1:0]       rd_rdata_o
);

   grant_e gnt;
   grant_e rd_owner_q;   // who issued the read that returns this cycle
   logic   host_req;

   assign host_req = (host_op_i != HOP_IDLE);

   // writes beat reads so the FIFO always drains
   assign host_gnt_o = host_req;
   assign wr_gnt_o   = wr_req_i && !host_req;
   assign rd_gnt_o   = rd_req_i && !host_req && !wr_req_i;

   always_comb begin
      if (host_gnt_o)    gnt = GNT_HOST;
      else if (wr_gnt_o) gnt = GNT_WR;
      else if (rd_gnt_o) gnt = GNT_RD;
      else               gnt = GNT_NONE;
   end

   assign mem_en_o   = (gnt != GNT_NONE);

   always_comb begin
      mem_req_o = '0;
      unique case (gnt)
         GNT_HOST: begin
            mem_req_o.we    = (host_op_i == HOP_WRITE);
            mem_req_o.addr  = host_addr_i;
            mem_req_o.wdata = host_wdata_i;
         end
         GNT_WR: begin
            mem_req_o.we    = 1'b1;
            mem_req_o.addr  = wr_addr_i;
            mem_req_o.wdata = wr_wdata_i;
         end
         GNT_RD: begin
            mem_req_o.addr = rd_addr_i;
         end
         default: begin
            mem_req_o = '0;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_owner_q <= GNT_NONE;
      end else if (gnt == GNT_HOST && host_op_i == HOP_READ) begin
         rd_owner_q <= GNT_HOST;
      end else if (gnt == GNT_RD) begin
         rd_owner_q <= GNT_RD;
      end else begin
         rd_owner_q <= GNT_NONE;
      end
   end

   assign host_rvalid_o = (rd_owner_q == GNT_HOST);
   assign rd_rvalid_o   = (rd_owner_q == GNT_RD);
   assign host_rdata_o  = mem_rdata_i;
   assign rd_rdata_o    = mem_rdata_i;

   a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0({host_gnt_o, wr_gnt_o, rd_gnt_o}));

endmodule

`default_nettype wire

//--- rtl/sp_memory.sv
`timescale 1ns/1ns
`default_nettype none

module sp_memory import copy_pkg::*; (
   input  wire logic         clk_i,
   input  wire mem_req_t     req_i,
   input  wire logic         en_i,
   output logic [DATA_W-1:0] rdata_o
);

   logic [DATA_W-1:0] mem_q [MEM_WORDS];

   // one access per cycle, read data shows up on the next edge
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (req_i.we) begin
            mem_q[req_i.addr] <= req_i.wdata;
         end else begin
            rdata_o <= mem_q[req_i.addr];
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/copy_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module copy_fifo import copy_pkg::*; (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   input  wire logic              push_i,
   input  wire logic [DATA_W-1:0] push_data_i,
   input  wire logic              pop_i,
   input  wire logic              reserve_i,
   output logic [DATA_W-1:0]      head_o,
   output logic                   not_empty_o,
   output logic                   has_room_o
);

   logic [DATA_W-1:0]     buf_q [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr_q;
   logic [FIFO_PTR_W-1:0] rd_ptr_q;
   logic [FIFO_PTR_W:0]   count_q;
   logic [FIFO_PTR_W:0]   in_flight_q;    // granted reads whose data has not arrived yet

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         buf_q[wr_ptr_q] <= push_data_i;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         count_q     <= '0;
         in_flight_q <= '0;
      end else begin
         if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
         count_q     <= count_q + push_i - pop_i;
         in_flight_q <= in_flight_q + reserve_i - push_i;
      end
   end

   assign head_o      = buf_q[rd_ptr_q];
   assign not_empty_o = (count_q != '0);
   assign has_room_o  = ((count_q + in_flight_q) < FIFO_DEPTH);

   a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
      push_i |-> (count_q < FIFO_DEPTH));

   a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
      pop_i |-> not_empty_o);

endmodule

`default_nettype wire

//--- rtl/copy_engine.sv
`timescale 1ns/1ns
`default_nettype none

module copy_engine import copy_pkg::*; (
   input  wire logic               clk_i,
   input  wire logic               rst_i,
   input  wire logic               run_i,
   input  wire agu_cfg_t           src_cfg_i,
   input  wire agu_cfg_t           dst_cfg_i,
   output logic                    busy_o,

   input  wire host_op_e           host_op_i,
   input  wire logic [WORD_AW-1:0] host_addr_i,
   input  wire logic [DATA_W-1:0]  host_wdata_i,
   output logic                    host_gnt_o,
   output logic                    host_rvalid_o,
   output logic [DATA_W-1:0]       host_rdata_o
);

   logic              src_valid;
   logic              src_done;
   logic [ADDR_W-1:0] src_addr;
   logic              dst_valid;
   logic              dst_done;
   logic [ADDR_W-1:0] dst_addr;

   logic              rd_req;
   logic              rd_gnt;
   logic              rd_rvalid;
   logic [DATA_W-1:0] rd_rdata;
   logic              wr_req;
   logic              wr_gnt;

   logic [DATA_W-1:0] fifo_head;
   logic              fifo_not_empty;
   logic              fifo_has_room;

   mem_req_t          mem_req;
   logic              mem_en;
   logic [DATA_W-1:0] mem_rdata;

   assign rd_req = src_valid & fifo_has_room;
   assign wr_req = dst_valid & fifo_not_empty;

   addr_gen src_agu (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .run_i   (run_i),
      .cfg_i   (src_cfg_i),
      .valid_o (src_valid),
      .ready_i (rd_gnt),
      .addr_o  (src_addr),
      .done_o  (src_done)
   );

   addr_gen dst_agu (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .run_i   (run_i),
      .cfg_i   (dst_cfg_i),
      .valid_o (dst_valid),
      .ready_i (wr_gnt),
      .addr_o  (dst_addr),
      .done_o  (dst_done)
   );

   copy_fifo fifo_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (rd_rvalid),
      .push_data_i (rd_rdata),
      .pop_i       (wr_gnt),
      .reserve_i   (rd_gnt),
      .head_o      (fifo_head),
      .not_empty_o (fifo_not_empty),
      .has_room_o  (fifo_has_room)
   );

   // byte addresses become word indexes here
   mem_arbiter arb_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .host_op_i     (host_op_i),
      .host_addr_i   (host_addr_i),
      .host_wdata_i  (host_wdata_i),
      .host_gnt_o    (host_gnt_o),
      .rd_req_i      (rd_req),
      .rd_addr_i     (src_addr[ADDR_W-1:OFFSET_W]),
      .rd_gnt_o      (rd_gnt),
      .wr_req_i      (wr_req),
      .wr_addr_i     (dst_addr[ADDR_W-1:OFFSET_W]),
      .wr_wdata_i    (fifo_head),
      .wr_gnt_o      (wr_gnt),
      .mem_req_o     (mem_req),
      .mem_en_o      (mem_en),
      .mem_rdata_i   (mem_rdata),
      .host_rvalid_o (host_rvalid_o),
      .host_rdata_o  (host_rdata_o),
      .rd_rvalid_o   (rd_rvalid),
      .rd_rdata_o    (rd_rdata)
   );

   sp_memory mem_i (
      .clk_i   (clk_i),
      .req_i   (mem_req),
      .en_i    (mem_en),
      .rdata_o (mem_rdata)
   );

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_o <= 1'b0;
      end else if (run_i) begin
         busy_o <= 1'b1;
      end else if (dst_done) begin
         busy_o <= 1'b0;   // the last write has been granted
      end
   end

   // every write needs a read first, so with equal counts the source ends first
   a_src_before_dst: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(dst_done) |-> src_done);

endmodule

`default_nettype wire

//--- tb/tb_copy_engine.sv
`timescale 1ns/1ns
`default_nettype none

module tb_copy_engine import copy_pkg::*; ();

   localparam int MAX_TESTS = 32;

   typedef int word_q_t[$];

   logic              clk;
   logic              rst;
   logic              run;
   agu_cfg_t          src_cfg;
   agu_cfg_t          dst_cfg;
   logic              busy;
   host_op_e          host_op;
   logic [WORD_AW-1:0] host_addr;
   logic [DATA_W-1:0] host_wdata;
   logic              host_gnt;
   logic              host_rvalid;
   logic [DATA_W-1:0] host_rdata;

   agu_cfg_t          src_cfgs [MAX_TESTS];
   agu_cfg_t          dst_cfgs [MAX_TESTS];
   int                exp_words [MAX_TESTS];
   bit                host_reads [MAX_TESTS];
   logic [11:0]       fields [16];
   logic [DATA_W-1:0] model [MEM_WORDS];      // memory contents before the copy
   logic [DATA_W-1:0] expect_mem [MEM_WORDS];
   bit                dst_hit [MEM_WORDS];
   int                n_tests;
   int                cycle_limit;
   int                cycle_cnt = 0;
   int                err_cnt;
   int                chk_cnt;
   integer            seed;

   copy_engine copy_engine_i (
      .clk_i         (clk),
      .rst_i         (rst),
      .run_i         (run),
      .src_cfg_i     (src_cfg),
      .dst_cfg_i     (dst_cfg),
      .busy_o        (busy),
      .host_op_i     (host_op),
      .host_addr_i   (host_addr),
      .host_wdata_i  (host_wdata),
      .host_gnt_o    (host_gnt),
      .host_rvalid_o (host_rvalid),
      .host_rdata_o  (host_rdata)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("timeout, the run did not finish within %0d cycles", cycle_limit);
         $display("tests %0d, checks %0d, errors %0d", n_tests, chk_cnt, err_cnt);
         $display("TESTS FAILED");
         $finish;
      end
   end

   function automatic agu_cfg_t cfg_from_fields(input int b);
      agu_cfg_t cfg;
      cfg.start      = fields[b];
      cfg.duty       = fields[b+1][PERIOD_W-1:0];
      cfg.period     = fields[b+2][PERIOD_W-1:0];
      cfg.incr       = fields[b+3];
      cfg.iterations = fields[b+4];
      cfg.shift      = fields[b+5];
      cfg.delay      = fields[b+6][DELAY_W-1:0];
      return cfg;
   endfunction

   // word indexes that one generator visits under the address rule
   function automatic word_q_t pattern_words(input agu_cfg_t cfg);
      word_q_t words;
      int addr;
      int steps;
      int iters;
      steps = (cfg.period == '0) ? 1 : int'(cfg.period);
      iters = (cfg.iterations == '0) ? 1 : int'(cfg.iterations);
      addr  = int'(cfg.start);
      for (int i = 0; i < iters; i++) begin
         for (int p = 0; p < steps; p++) begin
            words.push_back(addr / 4);
            if (p == steps - 1) begin
               if (i != iters - 1) addr = (addr + 4 * int'($signed(cfg.shift))) & 'hfff;
            end else if (p < int'(cfg.duty)) begin
               addr = (addr + 4 * int'($signed(cfg.incr))) & 'hfff;
            end
         end
      end
      return words;
   endfunction

   task automatic read_tests();
      int    fd;
      int    n;
      string line;
      n_tests = 0;
      fd = $fopen("tb/copy_engine_tests.txt", "r");
      if (fd == 0) begin
         err_cnt++;
         $display("could not open tb/copy_engine_tests.txt");
         return;
      end
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#") continue;   // comments and blank lines
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     fields[0], fields[1], fields[2], fields[3], fields[4], fields[5],
                     fields[6], fields[7], fields[8], fields[9], fields[10], fields[11],
                     fields[12], fields[13], fields[14], fields[15]);
         if (n != 16) begin
            err_cnt++;
            $display("test file line has %0d fields instead of 16: %s", n, line);
            continue;
         end
         src_cfgs[n_tests]   = cfg_from_fields(0);
         dst_cfgs[n_tests]   = cfg_from_fields(7);
         exp_words[n_tests]  = int'(fields[14]);
         host_reads[n_tests] = fields[15][0];
         n_tests++;
      end
      $fclose(fd);
   endtask

   task automatic host_write(input int word, input logic [DATA_W-1:0] data);
      @(posedge clk);
      host_op    <= HOP_WRITE;
      host_addr  <= WORD_AW'(word);
      host_wdata <= data;
      @(negedge clk);
      chk_cnt++;
      assert (host_gnt) else begin
         err_cnt++;
         $display("ERR host_gnt_o write word %03h: expected 1, got %h", word, host_gnt);
      end
   endtask

   task automatic host_idle();
      @(posedge clk);
      host_op <= HOP_IDLE;
   endtask

   // the grant comes with the request and the data exactly one cycle later
   task automatic host_read_check(input int word, input logic [DATA_W-1:0] want);
      @(posedge clk);
      host_op   <= HOP_READ;
      host_addr <= WORD_AW'(word);
      @(negedge clk);
      chk_cnt++;
      assert (host_gnt) else begin
         err_cnt++;
         $display("ERR host_gnt_o read word %03h: expected 1, got %h", word, host_gnt);
      end
      chk_cnt++;
      assert (!host_rvalid) else begin
         err_cnt++;
         $display("ERR host_rvalid_o word %03h in grant cycle: expected 0, got %h",
                  word, host_rvalid);
      end
      @(posedge clk);
      host_op <= HOP_IDLE;
      @(negedge clk);
      chk_cnt++;
      assert (host_rvalid) else begin
         err_cnt++;
         $display("ERR host_rvalid_o word %03h after grant: expected 1, got %h",
                  word, host_rvalid);
      end
      chk_cnt++;
      assert (host_rdata === want) else begin
         err_cnt++;
         $display("ERR host_rdata_o word %03h: expected %08h, got %08h", word, want, host_rdata);
      end
   endtask

   task automatic run_test(input int t);
      word_q_t           src_w;
      word_q_t           dst_w;
      logic [DATA_W-1:0] data;
      int                pick;
      src_w = pattern_words(src_cfgs[t]);
      dst_w = pattern_words(dst_cfgs[t]);
      chk_cnt++;
      assert (src_w.size() == exp_words[t] && dst_w.size() == exp_words[t]) else begin
         err_cnt++;
         $display("test %0d: patterns give %0d and %0d words but the file expects %0d",
                  t, src_w.size(), dst_w.size(), exp_words[t]);
      end
      for (int w = 0; w < MEM_WORDS; w++) begin
         data     = $random(seed);
         model[w] = data;
         host_write(w, data);
      end
      host_idle();
      expect_mem = model;
      for (int w = 0; w < MEM_WORDS; w++) dst_hit[w] = 1'b0;
      for (int i = 0; i < dst_w.size() && i < src_w.size(); i++) begin
         expect_mem[dst_w[i]] = model[src_w[i]];   // later writes to a word win
         dst_hit[dst_w[i]]    = 1'b1;
      end
      @(posedge clk);
      src_cfg <= src_cfgs[t];
      dst_cfg <= dst_cfgs[t];
      run     <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      @(negedge clk);
      chk_cnt++;
      assert (busy) else begin
         err_cnt++;
         $display("ERR busy_o test %0d after run_i: expected 1, got %h", t, busy);
      end
      while (busy) begin
         if (host_reads[t]) begin
            pick = $random(seed) & (MEM_WORDS - 1);
            if (!dst_hit[pick]) host_read_check(pick, model[pick]);
         end else begin
            @(negedge clk);
         end
      end
      for (int w = 0; w < MEM_WORDS; w++) host_read_check(w, expect_mem[w]);
      $display("test %0d done, %0d words copied", t, dst_w.size());
   endtask

   initial begin
      seed       = 32;
      err_cnt    = 0;
      chk_cnt    = 0;
      rst        = 1'b1;
      run        = 1'b0;
      src_cfg    = '0;
      dst_cfg    = '0;
      host_op    = HOP_IDLE;
      host_addr  = '0;
      host_wdata = '0;
      read_tests();
      cycle_limit = 1000 + 16;
      for (int t = 0; t < n_tests; t++) begin
         cycle_limit += 8 * exp_words[t] + int'(src_cfgs[t].delay) + int'(dst_cfgs[t].delay)
                        + 3 * MEM_WORDS + 8;   // fill, copy and readback
      end
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      host_write(10'h155, 32'ha5c3_0f96);
      host_read_check(10'h155, 32'ha5c3_0f96);
      for (int t = 0; t < n_tests; t++) run_test(t);
      $display("tests %0d, checks %0d, errors %0d", n_tests, chk_cnt, err_cnt);
      if (err_cnt == 0 && n_tests > 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
rtl/copy_pkg.sv
rtl/addr_gen.sv
rtl/mem_arbiter.sv
rtl/sp_memory.sv
rtl/copy_fifo.sv
rtl/copy_engine.sv
tb/tb_copy_engine.sv

//--- run_sim.sh
#!/bin/sh
# build the copy engine testbench with Verilator, run it and judge the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_copy_engine \
   -f project.f -o tb_copy_engine > build.log 2>&1 \
   || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_copy_engine > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

//--- tb/copy_engine_tests.txt
# one test per line, all fields hex: src start duty period incr iter shift delay,
# then dst start duty period incr iter shift delay, then word count and host reads (0/1)
100 20 20 001 000 000 00   800 20 20 001 000 000 00   20 0
000 02 04 001 008 005 00   c00 20 20 001 001 000 00   20 0
400 18 18 001 000 000 00   bfc 04 04 ffe 006 ffd 00   18 0
200 01 02 003 00a 001 30   900 14 14 001 001 000 7f   14 0
040 40 40 001 000 000 05   e00 08 08 001 008 001 00   40 1
ff0 08 08 001 001 000 00   600 00 00 000 008 002 00   08 0
